/* src/trigger_defs.svh */
`ifndef TRIGGER_DEFS_SVH
`define TRIGGER_DEFS_SVH

// channel count and sample geometry
`define NCHAN       8
`define NSAMP       4
`define NBITS       12
`define OUTBITS     5

// scaled sample width after the gain stage
`define SCALEBITS   17
// fraction bits of the 4.4 gain
`define GAIN_FRAC   4

// wishbone bus widths
`define WB_AW       22
`define WB_DW       32

// channel field in the address, register offset sits in bits 7:0
`define CHAN_LSB    10
`define CHAN_MSB    12

// register offsets inside one channel
`define REG_GAINOFS 8'h00
`define REG_CTRL    8'h04

// reset defaults, gain 16 is unity in 4.4
`define GAIN_RESET  16
`define SHIFT_RESET 8

`endif

/* src/trigger_pkg.sv */
`include "trigger_defs.svh"

package trigger_pkg;

    // one adc sample, four of them arrive per aclk
    typedef logic signed [`NBITS-1:0] sample_t;
    typedef sample_t [`NSAMP-1:0] in_word_t;

    // 5-bit trigger value and its word
    typedef logic signed [`OUTBITS-1:0] trig_t;
    typedef trig_t [`NSAMP-1:0] out_word_t;

    // sample after offset and gain, fraction bits dropped
    typedef logic signed [`SCALEBITS-1:0] scaled_t;
    typedef scaled_t [`NSAMP-1:0] scaled_word_t;

    // gain/offset register view, offset in the low bits
    typedef struct packed {
        logic [`WB_DW-25:0] rsvd;
        logic [7:0]         gain;
        logic [3:0]         pad;
        sample_t            offset;
    } gainofs_t;

    // control register view, enable is bit 0
    typedef struct packed {
        logic [`WB_DW-6:0] rsvd;
        logic [3:0]        shift;
        logic              enable;
    } ctrl_t;

    // one bus word, read as gain/offset or control by register offset
    typedef union packed {
        logic [`WB_DW-1:0] raw;
        gainofs_t          gainofs;
        ctrl_t             ctrl;
    } cfg_word_u;

    // live configuration of one channel
    typedef struct packed {
        logic [7:0] gain;
        sample_t    offset;
        logic       enable;
        logic [3:0] shift;
    } chan_cfg_t;

    // request from the decoder to one channel
    typedef struct packed {
        logic       sel;
        logic       we;
        logic [7:0] offs;
        cfg_word_u  data;
    } reg_cmd_t;

endpackage

/* src/wb_chan_decode.sv */
`include "trigger_defs.svh"

module wb_chan_decode (
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [`WB_AW-1:0]                 wb_adr_i,
    input  logic [`WB_DW-1:0]                 wb_dat_i,
    input  logic [`NCHAN-1:0]                 chan_ack_i,
    input  logic [`NCHAN-1:0][`WB_DW-1:0]     chan_dat_i,
    output logic                              wb_ack_o,
    output logic [`WB_DW-1:0]                 wb_dat_o,
    output trigger_pkg::reg_cmd_t [`NCHAN-1:0] cmd_o
);

    // channel index from bits 12:10
    logic [`CHAN_MSB-`CHAN_LSB:0] chan_idx;
    // register offset inside the channel
    logic [7:0]                   reg_offs;
    // a live bus request this cycle
    logic                         req;

    // bits 9:8 and everything above 12 are don't care
    assign chan_idx = wb_adr_i[`CHAN_MSB:`CHAN_LSB];
    assign reg_offs = wb_adr_i[7:0];
    assign req      = wb_cyc_i & wb_stb_i;

    // fan the request out, only the addressed channel sees sel
    always_comb begin
        for (int c = 0; c < `NCHAN; c++) begin
            // hold off while that channel is still acking the last access
            cmd_o[c].sel      = req && (chan_idx == c) && !chan_ack_i[c];
            cmd_o[c].we       = wb_we_i;
            cmd_o[c].offs     = reg_offs;
            cmd_o[c].data.raw = wb_dat_i;
        end
    end

    // master holds the address until ack, so the same index picks the reply
    assign wb_ack_o = chan_ack_i[chan_idx];
    assign wb_dat_o = chan_dat_i[chan_idx];

endmodule

/* src/chain_regs.sv */
`include "trigger_defs.svh"

module chain_regs (
    input  logic                   aclk,
    input  logic                   reset_i,
    input  logic                   agc_reset_i,
    input  trigger_pkg::reg_cmd_t  cmd_i,
    output logic                   ack_o,
    output logic [`WB_DW-1:0]      rdat_o,
    output trigger_pkg::chan_cfg_t cfg_o
);

    trigger_pkg::chan_cfg_t cfg_q;
    logic                   ack_q;
    // write waiting to land at the end of the ack cycle
    logic                   wr_pend_q;
    logic [7:0]             wr_offs_q;
    trigger_pkg::cfg_word_u wr_data_q;
    // read word built through the union
    trigger_pkg::cfg_word_u rd_word;
    // request accepted this cycle
    logic                   take;

    // the decoder holds sel low while this channel acks
    assign take = cmd_i.sel;

    // ack follows the request by one cycle
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            ack_q     <= 1'b0;
            wr_pend_q <= 1'b0;
        end else begin
            ack_q     <= take;
            wr_pend_q <= take & cmd_i.we;
        end
    end

    // write payload and read word captured with the request
    always_ff @(posedge aclk) begin
        if (take) begin
            wr_offs_q <= cmd_i.offs;
            wr_data_q <= cmd_i.data;
            rdat_o    <= rd_word.raw;
        end
    end

    // unknown offsets read as zero
    always_comb begin
        rd_word.raw = '0;
        case (cmd_i.offs)
            `REG_GAINOFS: begin
                rd_word.gainofs.gain   = cfg_q.gain;
                rd_word.gainofs.offset = cfg_q.offset;
            end
            `REG_CTRL: begin
                rd_word.ctrl.enable = cfg_q.enable;
                rd_word.ctrl.shift  = cfg_q.shift;
            end
            default: ;
        endcase
    end

    // config changes at the edge closing the ack cycle
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            cfg_q.gain   <= 8'(`GAIN_RESET);
            cfg_q.offset <= '0;
            cfg_q.enable <= 1'b1;
            cfg_q.shift  <= 4'(`SHIFT_RESET);
        end else begin
            if (wr_pend_q && wr_offs_q == `REG_CTRL) begin
                cfg_q.enable <= wr_data_q.ctrl.enable;
                cfg_q.shift  <= wr_data_q.ctrl.shift;
            end
            // agc reset beats a gain/offset write in the same cycle
            if (agc_reset_i) begin
                cfg_q.gain   <= 8'(`GAIN_RESET);
                cfg_q.offset <= '0;
            end else if (wr_pend_q && wr_offs_q == `REG_GAINOFS) begin
                cfg_q.gain   <= wr_data_q.gainofs.gain;
                cfg_q.offset <= wr_data_q.gainofs.offset;
            end
        end
    end

    assign ack_o = ack_q;
    assign cfg_o = cfg_q;

    ack_single: assert property (@(posedge aclk) disable iff (reset_i) ack_q |=> !ack_q)
        else $error("chain_regs: ack high in two consecutive cycles");

endmodule

/* src/agc_scale.sv */
`include "trigger_defs.svh"

module agc_scale (
    input  logic                      aclk,
    input  logic                      reset_i,
    input  trigger_pkg::in_word_t     dat_i,
    input  trigger_pkg::chan_cfg_t    cfg_i,
    output trigger_pkg::scaled_word_t dat_o
);

    // sample minus offset needs one extra bit
    localparam int DIFFBITS = `NBITS + 1;
    // gain goes in as a 9-bit signed, zero extended
    localparam int PRODBITS = DIFFBITS + 9;
    // product with the gain fraction dropped
    localparam int SHFTBITS = PRODBITS - `GAIN_FRAC;

    logic signed [DIFFBITS-1:0] diff    [`NSAMP];
    logic signed [PRODBITS-1:0] prod    [`NSAMP];
    logic signed [SHFTBITS-1:0] shifted [`NSAMP];
    // lane result fits the scaled width
    logic [`NSAMP-1:0]          fits;

    // four lanes side by side, all share the channel config
    always_comb begin
        for (int k = 0; k < `NSAMP; k++) begin
            diff[k] = $signed({dat_i[k][`NBITS-1], dat_i[k]})
                    - $signed({cfg_i.offset[`NBITS-1], cfg_i.offset});
            prod[k] = diff[k] * $signed({1'b0, cfg_i.gain});
            // arithmetic shift by 4 is just dropping the low bits
            shifted[k] = prod[k][PRODBITS-1:`GAIN_FRAC];
            // upper bits must all copy the sign bit
            fits[k] = (&shifted[k][SHFTBITS-1:`SCALEBITS-1])
                    | ~(|shifted[k][SHFTBITS-1:`SCALEBITS-1]);
        end
    end

    // first pipeline register
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            dat_o <= '0;
        end else begin
            for (int k = 0; k < `NSAMP; k++) begin
                dat_o[k] <= shifted[k][`SCALEBITS-1:0];
            end
        end
    end

    scale_fits: assert property (@(posedge aclk) disable iff (reset_i) &fits)
        else $error("agc_scale: scaled sample overflows %0d bits", `SCALEBITS);

endmodule

/* src/out_quantize.sv */
`include "trigger_defs.svh"

module out_quantize (
    input  logic                      aclk,
    input  logic                      reset_i,
    input  trigger_pkg::scaled_word_t dat_i,
    input  trigger_pkg::chan_cfg_t    cfg_i,
    output trigger_pkg::out_word_t    dat_o
);

    localparam int TRIG_MAX = 2 ** (`OUTBITS - 1) - 1;
    localparam int TRIG_MIN = -(2 ** (`OUTBITS - 1));

    // enable and shift follow their word one stage late
    logic                   en_q;
    logic [3:0]             shift_q;
    trigger_pkg::scaled_t   shifted [`NSAMP];
    trigger_pkg::out_word_t qnt;
    // lanes clipped at the top or bottom limit
    logic [`NSAMP-1:0]      sat_hi;
    logic [`NSAMP-1:0]      sat_lo;

    // snapshot taken when the word enters agc_scale
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            en_q    <= 1'b0;
            shift_q <= '0;
        end else begin
            en_q    <= cfg_i.enable;
            shift_q <= cfg_i.shift;
        end
    end

    always_comb begin
        for (int k = 0; k < `NSAMP; k++) begin
            shifted[k] = $signed(dat_i[k]) >>> shift_q;
            sat_hi[k]  = shifted[k] > TRIG_MAX;
            sat_lo[k]  = shifted[k] < TRIG_MIN;
            // disabled channel outputs zero
            if (!en_q)
                qnt[k] = '0;
            else if (sat_hi[k])
                qnt[k] = trigger_pkg::trig_t'(TRIG_MAX);
            else if (sat_lo[k])
                qnt[k] = trigger_pkg::trig_t'(TRIG_MIN);
            else
                qnt[k] = shifted[k][`OUTBITS-1:0];
        end
    end

    // second pipeline register
    always_ff @(posedge aclk) begin
        if (reset_i)
            dat_o <= '0;
        else
            dat_o <= qnt;
    end

    for (genvar k = 0; k < `NSAMP; k++) begin : g_sat_chk
        sat_limit: assert property (@(posedge aclk) disable iff (reset_i)
            (en_q && (sat_hi[k] || sat_lo[k])) |=>
                (dat_o[k] == trigger_pkg::trig_t'(TRIG_MAX)
                 || dat_o[k] == trigger_pkg::trig_t'(TRIG_MIN)))
            else $error("out_quantize: lane %0d not held at a limit", k);
    end

endmodule

/* src/trigger_chain.sv */
`include "trigger_defs.svh"

module trigger_chain (
    input  logic                   aclk,
    input  logic                   reset_i,
    input  logic                   agc_reset_i,
    input  trigger_pkg::reg_cmd_t  cmd_i,
    output logic                   ack_o,
    output logic [`WB_DW-1:0]      rdat_o,
    input  trigger_pkg::in_word_t  dat_i,
    output trigger_pkg::out_word_t dat_o
);

    // config level shared by both stages
    trigger_pkg::chan_cfg_t    cfg;
    // word between the gain and quantize stages
    trigger_pkg::scaled_word_t scaled;

    chain_regs u_regs (
        .aclk        (aclk),
        .reset_i     (reset_i),
        .agc_reset_i (agc_reset_i),
        .cmd_i       (cmd_i),
        .ack_o       (ack_o),
        .rdat_o      (rdat_o),
        .cfg_o       (cfg)
    );

    // stage 1, offset and gain
    agc_scale u_scale (
        .aclk    (aclk),
        .reset_i (reset_i),
        .dat_i   (dat_i),
        .cfg_i   (cfg),
        .dat_o   (scaled)
    );

    // stage 2, shift, clip, enable
    out_quantize u_quant (
        .aclk    (aclk),
        .reset_i (reset_i),
        .dat_i   (scaled),
        .cfg_i   (cfg),
        .dat_o   (dat_o)
    );

endmodule

/* src/trigger_chain_x8.sv */
`include "trigger_defs.svh"

module trigger_chain_x8 (
    input  logic                                   aclk,
    input  logic                                   reset_i,
    input  logic                                   agc_reset_i,
    input  logic                                   wb_cyc_i,
    input  logic                                   wb_stb_i,
    input  logic                                   wb_we_i,
    input  logic [`WB_AW-1:0]                      wb_adr_i,
    // whole-word accesses only, byte selects are not looked at
    input  logic [`WB_DW/8-1:0]                    wb_sel_i,
    input  logic [`WB_DW-1:0]                      wb_dat_i,
    output logic                                   wb_ack_o,
    output logic [`WB_DW-1:0]                      wb_dat_o,
    input  trigger_pkg::in_word_t  [`NCHAN-1:0]    dat_i,
    output trigger_pkg::out_word_t [`NCHAN-1:0]    dat_o
);

    trigger_pkg::reg_cmd_t [`NCHAN-1:0] cmd;
    logic [`NCHAN-1:0]                  chan_ack;
    logic [`NCHAN-1:0][`WB_DW-1:0]      chan_dat;

    wb_chan_decode u_dec (
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .chan_ack_i (chan_ack),
        .chan_dat_i (chan_dat),
        .wb_ack_o   (wb_ack_o),
        .wb_dat_o   (wb_dat_o),
        .cmd_o      (cmd)
    );

    // one chain per channel, all on aclk
    for (genvar c = 0; c < `NCHAN; c++) begin : g_chan
        trigger_chain u_chain (
            .aclk        (aclk),
            .reset_i     (reset_i),
            .agc_reset_i (agc_reset_i),
            .cmd_i       (cmd[c]),
            .ack_o       (chan_ack[c]),
            .rdat_o      (chan_dat[c]),
            .dat_i       (dat_i[c]),
            .dat_o       (dat_o[c])
        );
    end

endmodule

/* dv/chain_checker.sv */
`include "trigger_defs.svh"

module chain_checker (
    input  logic                                aclk,
    input  logic                                reset_i,
    input  logic                                agc_reset_i,
    input  logic                                wb_cyc_i,
    input  logic                                wb_stb_i,
    input  logic                                wb_we_i,
    input  logic [`WB_AW-1:0]                   wb_adr_i,
    input  logic [`WB_DW-1:0]                   wb_dat_i,
    input  logic                                wb_ack_o,
    input  logic [`WB_DW-1:0]                   wb_dat_o,
    input  trigger_pkg::in_word_t  [`NCHAN-1:0] dat_i,
    input  trigger_pkg::out_word_t [`NCHAN-1:0] dat_o,
    input  logic                                gold_valid_i,
    input  trigger_pkg::out_word_t [`NCHAN-1:0] gold_exp_i,
    input  logic                                rd_valid_i,
    input  logic [`WB_DW-1:0]                   rd_exp_i,
    output int                                  errors_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // config model per channel
    int gain[`NCHAN];
    int ofs[`NCHAN];
    int shamt[`NCHAN];
    bit en[`NCHAN];
    // two stage delay of predicted and golden words
    trigger_pkg::out_word_t [`NCHAN-1:0] exp1, exp2, g1, g2;
    logic gv1, gv2;
    bit   ack_due;
    int   checks = 0;
    int   errors = 0;

    assign errors_o = errors;

    // offset, gain with 4 fraction bits, shift, clip, enable
    function automatic trigger_pkg::out_word_t model_word(trigger_pkg::in_word_t w, int c);
        int s;
        int sc;
        int t;
        trigger_pkg::out_word_t r;
        for (int k = 0; k < `NSAMP; k++) begin
            s  = $signed(w[k]);
            sc = ((s - ofs[c]) * gain[c]) >>> 4;
            t  = sc >>> shamt[c];
            if (t > 15)
                t = 15;
            if (t < -16)
                t = -16;
            r[k] = en[c] ? t[4:0] : 5'd0;
        end
        return r;
    endfunction

    // register layout: gain 23:16, offset 11:0; shift 4:1, enable 0
    function automatic logic [31:0] reg_word(int c, int offs);
        if (offs == 0)
            return {8'h00, gain[c][7:0], 4'h0, ofs[c][11:0]};
        else if (offs == 4)
            return {27'd0, shamt[c][3:0], en[c]};
        return 32'd0;
    endfunction

    task automatic print_counts();
        $display("checker: %0d checks, %0d errors", checks, errors);
    endtask

    always @(posedge aclk) begin : watch
        int ch;
        int offs;
        ch   = wb_adr_i[`CHAN_MSB:`CHAN_LSB];
        offs = wb_adr_i[7:0];
        if (reset_i) begin
            for (int c = 0; c < `NCHAN; c++) begin
                gain[c]  = 16;
                ofs[c]   = 0;
                en[c]    = 1'b1;
                shamt[c] = 8;
            end
            exp1    = '0;
            exp2    = '0;
            gv1     = 1'b0;
            gv2     = 1'b0;
            ack_due = 1'b0;
        end else begin
            for (int c = 0; c < `NCHAN; c++) begin
                checks++;
                if (dat_o[c] !== exp2[c]) begin
                    errors++;
                    $display("[FAIL] dat_o[%0d] expected %h got %h", c, exp2[c], dat_o[c]);
                end
                if (gv2 && dat_o[c] !== g2[c]) begin
                    errors++;
                    $display("[FAIL] dat_o[%0d] golden %h got %h", c, g2[c], dat_o[c]);
                end
            end
            exp2 = exp1;
            gv2  = gv1;
            g2   = g1;
            // words entering stage 1 now see the config before this edge
            for (int c = 0; c < `NCHAN; c++)
                exp1[c] = model_word(dat_i[c], c);
            gv1 = gold_valid_i;
            g1  = gold_exp_i;

            if (ack_due && !wb_ack_o) begin
                errors++;
                $display("no ack one cycle after the bus request");
            end else if (!ack_due && wb_ack_o) begin
                errors++;
                $display("ack seen without a request one cycle earlier");
            end
            if (wb_ack_o && wb_we_i) begin
                if (offs == 0) begin
                    gain[ch] = int'(wb_dat_i[23:16]);
                    ofs[ch]  = int'($signed(wb_dat_i[11:0]));
                end else if (offs == 4) begin
                    en[ch]    = wb_dat_i[0];
                    shamt[ch] = int'(wb_dat_i[4:1]);
                end
            end else if (wb_ack_o) begin
                checks++;
                if (wb_dat_o !== reg_word(ch, offs)) begin
                    errors++;
                    $display("[FAIL] wb_dat_o expected %h got %h", reg_word(ch, offs), wb_dat_o);
                end
                if (rd_valid_i && wb_dat_o !== rd_exp_i) begin
                    errors++;
                    $display("[FAIL] wb_dat_o golden %h got %h", rd_exp_i, wb_dat_o);
                end
            end
            ack_due = wb_cyc_i && wb_stb_i && !wb_ack_o && !ack_due;
            // agc reset wins over a gain/offset write at the same edge
            if (agc_reset_i) begin
                for (int c = 0; c < `NCHAN; c++) begin
                    gain[c] = 16;
                    ofs[c]  = 0;
                end
            end
        end
    end

endmodule

/* dv/tb_trigger_chain.sv */
`include "trigger_defs.svh"

module tb_trigger_chain;

    timeunit 1ns;
    timeprecision 1ps;

    // random sample words after the golden lines
    localparam int NRAND = 64;

    logic                                 aclk;
    logic                                 reset_i;
    logic                                 agc_reset_i;
    logic                                 wb_cyc_i;
    logic                                 wb_stb_i;
    logic                                 wb_we_i;
    logic [`WB_AW-1:0]                    wb_adr_i;
    logic [`WB_DW/8-1:0]                  wb_sel_i;
    logic [`WB_DW-1:0]                    wb_dat_i;
    logic                                 wb_ack_o;
    logic [`WB_DW-1:0]                    wb_dat_o;
    trigger_pkg::in_word_t  [`NCHAN-1:0]  dat_i;
    trigger_pkg::out_word_t [`NCHAN-1:0]  dat_o;
    // golden expectations handed to the checker with the stimulus
    logic                                 gold_valid;
    trigger_pkg::out_word_t [`NCHAN-1:0]  gold_exp;
    logic                                 rd_valid;
    logic [`WB_DW-1:0]                    rd_exp;
    int                                   errors;
    int                                   cycles = 0;
    int                                   limit = 0;
    int                                   bad_lines = 0;
    logic [31:0]                          lcg_state = 32'h3983_6720;

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    trigger_chain_x8 dut0 (
        .aclk(aclk), .reset_i(reset_i), .agc_reset_i(agc_reset_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_sel_i(wb_sel_i), .wb_dat_i(wb_dat_i),
        .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o), .dat_i(dat_i), .dat_o(dat_o)
    );

    chain_checker u_chk (
        .aclk(aclk), .reset_i(reset_i), .agc_reset_i(agc_reset_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_ack_o(wb_ack_o),
        .wb_dat_o(wb_dat_o), .dat_i(dat_i), .dat_o(dat_o),
        .gold_valid_i(gold_valid), .gold_exp_i(gold_exp),
        .rd_valid_i(rd_valid), .rd_exp_i(rd_exp), .errors_o(errors)
    );

    // run limit is set once the golden file is loaded
    always @(posedge aclk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run exceeded %0d cycles", limit);
            u_chk.print_counts();
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // single classic cycle where a read carries its expected word as data
    task automatic bus_access(input logic we, input logic [`WB_AW-1:0] adr,
                              input logic [`WB_DW-1:0] data);
        @(posedge aclk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= we ? data : '0;
        rd_valid <= !we;
        rd_exp   <= data;
        do @(posedge aclk); while (!wb_ack_o);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        rd_valid <= 1'b0;
    endtask

    // one word per channel with the golden check in the first cycle only
    task automatic sample_step(input trigger_pkg::in_word_t [`NCHAN-1:0] w,
                               input trigger_pkg::out_word_t [`NCHAN-1:0] e,
                               input logic valid);
        @(posedge aclk);
        dat_i      <= w;
        gold_exp   <= e;
        gold_valid <= valid;
        @(posedge aclk);
        gold_valid <= 1'b0;
    endtask

    task automatic agc_pulse();
        @(posedge aclk);
        agc_reset_i <= 1'b1;
        @(posedge aclk);
        agc_reset_i <= 1'b0;
    endtask

    initial begin
        int                                  fd;
        int                                  n;
        string                               line;
        string                               lines[$];
        logic [`WB_AW-1:0]                   adr;
        logic [`WB_DW-1:0]                   data;
        logic [47:0]                         win;
        logic [19:0]                         ev[`NCHAN];
        logic [31:0]                         r_hi;
        logic [31:0]                         r_lo;
        trigger_pkg::in_word_t  [`NCHAN-1:0] w;
        trigger_pkg::out_word_t [`NCHAN-1:0] e;

        reset_i     = 1'b1;
        agc_reset_i = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_sel_i    = '1;
        wb_dat_i    = '0;
        dat_i       = '0;
        gold_valid  = 1'b0;
        gold_exp    = '0;
        rd_valid    = 1'b0;
        rd_exp      = '0;

        fd = $fopen("dv/trigger_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/trigger_golden.txt");
            bad_lines++;
        end else begin
            while ($fgets(line, fd))
                lines.push_back(line);
            $fclose(fd);
        end
        limit = 4 * lines.size() + NRAND + 100;

        repeat (2) @(posedge aclk);
        reset_i <= 1'b0;

        foreach (lines[i]) begin
            line = lines[i];
            if (line.len() < 2 || line[0] == "#")
                continue;
            case (line[0])
                "W", "R": begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h", adr, data);
                    if (n != 2) begin
                        bad_lines++;
                        $display("golden line %0d could not be parsed", i + 1);
                    end else begin
                        bus_access(line[0] == "W", adr, data);
                    end
                end
                "S": begin
                    n = $sscanf(line.substr(2, line.len() - 1),
                                "%h %h %h %h %h %h %h %h %h", win,
                                ev[0], ev[1], ev[2], ev[3], ev[4], ev[5], ev[6], ev[7]);
                    if (n != 9) begin
                        bad_lines++;
                        $display("golden line %0d could not be parsed", i + 1);
                    end else begin
                        for (int c = 0; c < `NCHAN; c++) begin
                            w[c] = win;
                            e[c] = ev[c];
                        end
                        sample_step(w, e, 1'b1);
                    end
                end
                "A": agc_pulse();
                default: begin
                    bad_lines++;
                    $display("golden line %0d has an unknown command", i + 1);
                end
            endcase
        end

        // the checker predicts the random words from its config model
        for (int r = 0; r < NRAND; r++) begin
            for (int c = 0; c < `NCHAN; c++) begin
                r_hi = lcg_next();
                r_lo = lcg_next();
                w[c] = {r_hi[15:0], r_lo};
            end
            @(posedge aclk);
            dat_i <= w;
        end

        // let the last words drain through both stages
        repeat (4) @(posedge aclk);
        u_chk.print_counts();
        if (errors == 0 && bad_lines == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* dv/trigger_golden.txt */
# W/R: address data (read: expected word); A: agc reset pulse; all hex
# S: input word for every channel, then expected output words ch0..ch7
R 000000 00100000
R 000004 00000011
R 000400 00100000
R 000404 00000011
R 000800 00100000
R 000804 00000011
R 000C00 00100000
R 000C04 00000011
R 001000 00100000
R 001004 00000011
R 001400 00100000
R 001404 00000011
R 001800 00100000
R 001804 00000011
R 001C00 00100000
R 001C04 00000011
S 7FF800100000 3E020 3E020 3E020 3E020 3E020 3E020 3E020 3E020
W 000000 00400000
W 000400 00100100
W 000800 00080000
W 000C00 00100010
W 001000 00100FF0
W 3FF700 00180000
W 001800 000C0000
W 001C00 001007FF
R 000000 00400000
R 000400 00100100
R 001000 00100FF0
R 001400 00180000
R 001C00 001007FF
R 000C04 00000011
S 7FF800100000 7C080 35C1F 1F000 3DC1F 46020 5D020 2E800 04338
W 000C04 00000010
W 000804 00000009
S 7FF800100000 7C080 35C1F 7C100 00000 46020 5D020 2E800 04338
A
R 000000 00100000
R 001C00 00100000
R 000804 00000009
R 000C04 00000010
S 7FF800100000 3E020 3E020 7C1E0 00000 3E020 3E020 3E020 3E020

/* tb.f */
+incdir+src
src/trigger_pkg.sv
src/wb_chan_decode.sv
src/chain_regs.sv
src/agc_scale.sv
src/out_quantize.sv
src/trigger_chain.sv
src/trigger_chain_x8.sv
dv/chain_checker.sv
dv/tb_trigger_chain.sv

/* Bender.yml */
package:
  name: trigger_chain

sources:
  - include_dirs:
      - src
    files:
      - src/trigger_pkg.sv
      - src/wb_chan_decode.sv
      - src/chain_regs.sv
      - src/agc_scale.sv
      - src/out_quantize.sv
      - src/trigger_chain.sv
      - src/trigger_chain_x8.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - dv/chain_checker.sv
      - dv/tb_trigger_chain.sv
